// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== decoder.sv ====
// decode stage register, immediates, control decode and operand forwarding
`timescale 1ns/100ps
module decoder (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [seed_pkg::XLEN-1:0]       f_pc_i,
    input  logic [seed_pkg::ILEN-1:0]       f_inst_i,
    input  logic                           f_valid_i,
    input  logic                           kill_i,
    output logic [seed_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [seed_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [seed_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [seed_pkg::XLEN-1:0]       rs2_data_i,
    input  logic                           ex_fwd_we_i,
    input  logic [seed_pkg::REG_ADDR_W-1:0] ex_fwd_rd_i,
    input  logic [seed_pkg::XLEN-1:0]       ex_fwd_data_i,
    input  logic                           rt_fwd_we_i,
    input  logic [seed_pkg::REG_ADDR_W-1:0] rt_fwd_rd_i,
    input  logic [seed_pkg::XLEN-1:0]       rt_fwd_data_i,
    output logic                           d_valid_o,
    output logic [seed_pkg::XLEN-1:0]       d_pc_o,
    output logic [seed_pkg::XLEN-1:0]       d_op_a_o,
    output logic [seed_pkg::XLEN-1:0]       d_op_b_o,
    output logic [seed_pkg::XLEN-1:0]       d_imm_o,
    output seed_pkg::alu_op_e              d_alu_op_o,
    output seed_pkg::br_kind_e             d_br_kind_o,
    output logic [seed_pkg::REG_ADDR_W-1:0] d_rd_o,
    output logic                           d_we_o,
    output logic                           d_use_imm_o,
    output logic                           d_ebreak_o
);
    import seed_pkg::*;

    logic            valid_q;
    logic [XLEN-1:0] pc_q;
    logic [ILEN-1:0] inst_q;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i, imm_b, imm_j, imm_u;
    logic            known;
    logic            alt;   // inst[30] selects sub or sra

    always_ff @(posedge clk) begin
        if (reset_i)
            valid_q <= 1'b0;
        else
            valid_q <= f_valid_i & ~kill_i; // shadow of a taken branch
        pc_q   <= f_pc_i;
        inst_q <= f_inst_i;
    end

    assign opcode = opcode_e'(inst_q[6:0]);
    assign funct3 = inst_q[14:12];
    assign alt    = inst_q[30];

    assign imm_i = {{52{inst_q[31]}}, inst_q[31:20]};
    assign imm_b = {{52{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    assign imm_j = {{44{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
    assign imm_u = {{32{inst_q[31]}}, inst_q[31:12], 12'b0};

    always_comb begin
        d_alu_op_o  = ALU_ADD;
        d_br_kind_o = BR_NONE;
        d_we_o      = 1'b0;
        d_use_imm_o = 1'b0;
        d_imm_o     = imm_i;
        d_ebreak_o  = 1'b0;
        known       = 1'b1;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                d_we_o      = 1'b1;
                d_use_imm_o = (opcode == OPC_OP_IMM);
                case (funct3)
                    F3_ADD_SUB: d_alu_op_o = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     d_alu_op_o = ALU_SLL;
                    F3_SLT:     d_alu_op_o = ALU_SLT;
                    F3_SLTU:    d_alu_op_o = ALU_SLTU;
                    F3_XOR:     d_alu_op_o = ALU_XOR;
                    F3_SRL_SRA: d_alu_op_o = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      d_alu_op_o = ALU_OR;
                    F3_AND:     d_alu_op_o = ALU_AND;
                    default:    d_alu_op_o = ALU_ADD;
                endcase
            end
            OPC_LUI: begin
                d_we_o      = 1'b1;
                d_use_imm_o = 1'b1;
                d_imm_o     = imm_u;
                d_alu_op_o  = ALU_PASS_B;
            end
            OPC_BRANCH: begin
                d_imm_o = imm_b;
                case (funct3)
                    F3_BEQ:  d_br_kind_o = BR_EQ;
                    F3_BNE:  d_br_kind_o = BR_NE;
                    F3_BLT:  d_br_kind_o = BR_LT;
                    F3_BGE:  d_br_kind_o = BR_GE;
                    default: known = 1'b0; // bltu / bgeu not supported
                endcase
            end
            OPC_JAL: begin
                d_we_o      = 1'b1;
                d_imm_o     = imm_j;
                d_br_kind_o = BR_JUMP;
            end
            OPC_JALR: begin
                d_we_o      = 1'b1;
                d_br_kind_o = BR_JUMPR;
                known       = (funct3 == F3_JALR);
            end
            OPC_SYSTEM: begin
                d_ebreak_o = (inst_q == EBREAK_INST);
                known      = d_ebreak_o;
            end
            default: known = 1'b0;
        endcase
    end

    // execute wins over retire, retire over the register file
    function automatic logic [XLEN-1:0] pick_operand(input logic [REG_ADDR_W-1:0] addr,
                                                     input logic [XLEN-1:0] rf_data);
        if (ex_fwd_we_i && ex_fwd_rd_i != '0 && ex_fwd_rd_i == addr)
            return ex_fwd_data_i;
        if (rt_fwd_we_i && rt_fwd_rd_i != '0 && rt_fwd_rd_i == addr)
            return rt_fwd_data_i;
        return rf_data;
    endfunction

    assign rs1_addr_o = inst_q[19:15];
    assign rs2_addr_o = inst_q[24:20];

    always_comb begin
        d_op_a_o = pick_operand(rs1_addr_o, rs1_data_i);
        d_op_b_o = pick_operand(rs2_addr_o, rs2_data_i);
    end

    assign d_valid_o = valid_q & known; // unknown opcode becomes a bubble
    assign d_pc_o    = pc_q;
    assign d_rd_o    = inst_q[11:7];

endmodule

// ==== execute_unit.sv ====
// execute stage: stage register, ALU, branch compare and pc redirect
`timescale 1ns/100ps
module execute_unit (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           d_valid_i,
    input  logic [seed_pkg::XLEN-1:0]       d_pc_i,
    input  logic [seed_pkg::XLEN-1:0]       d_op_a_i,
    input  logic [seed_pkg::XLEN-1:0]       d_op_b_i,
    input  logic [seed_pkg::XLEN-1:0]       d_imm_i,
    input  seed_pkg::alu_op_e              d_alu_op_i,
    input  seed_pkg::br_kind_e             d_br_kind_i,
    input  logic [seed_pkg::REG_ADDR_W-1:0] d_rd_i,
    input  logic                           d_we_i,
    input  logic                           d_use_imm_i,
    input  logic                           d_ebreak_i,
    output logic                           redirect_o,
    output logic [seed_pkg::XLEN-1:0]       target_o,
    output logic                           kill_o,
    output logic                           ex_valid_o,
    output logic [seed_pkg::XLEN-1:0]       ex_pc_o,
    output logic [seed_pkg::REG_ADDR_W-1:0] ex_rd_o,
    output logic                           ex_we_o,
    output logic [seed_pkg::XLEN-1:0]       ex_result_o,
    output logic                           ex_ebreak_o
);
    import seed_pkg::*;

    logic                  valid_q;
    logic [XLEN-1:0]       pc_q, op_a_q, op_b_q, imm_q;
    alu_op_e               alu_op_q;
    br_kind_e              br_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic                  we_q, use_imm_q, ebreak_q;

    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic [5:0]      shamt;
    logic            taken;
    logic            is_jump;

    always_ff @(posedge clk) begin
        if (reset_i)
            valid_q <= 1'b0;
        else
            valid_q <= d_valid_i & ~kill_o; // drop the instruction behind a taken branch
        pc_q      <= d_pc_i;
        op_a_q    <= d_op_a_i;
        op_b_q    <= d_op_b_i;
        imm_q     <= d_imm_i;
        alu_op_q  <= d_alu_op_i;
        br_q      <= d_br_kind_i;
        rd_q      <= d_rd_i;
        we_q      <= d_we_i;
        use_imm_q <= d_use_imm_i;
        ebreak_q  <= d_ebreak_i;
    end

    assign alu_b = use_imm_q ? imm_q : op_b_q;
    assign shamt = alu_b[5:0];  // rv64 shift amount

    always_comb begin
        case (alu_op_q)
            ALU_ADD:    alu_res = op_a_q + alu_b;
            ALU_SUB:    alu_res = op_a_q - alu_b;
            ALU_AND:    alu_res = op_a_q & alu_b;
            ALU_OR:     alu_res = op_a_q | alu_b;
            ALU_XOR:    alu_res = op_a_q ^ alu_b;
            ALU_SLL:    alu_res = op_a_q << shamt;
            ALU_SRL:    alu_res = op_a_q >> shamt;
            ALU_SRA:    alu_res = $signed(op_a_q) >>> shamt;
            ALU_SLT:    alu_res = {63'b0, $signed(op_a_q) < $signed(alu_b)};
            ALU_SLTU:   alu_res = {63'b0, op_a_q < alu_b};
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = '0;
        endcase
    end

    // branches compare the two register operands
    always_comb begin
        case (br_q)
            BR_EQ:             taken = (op_a_q == op_b_q);
            BR_NE:             taken = (op_a_q != op_b_q);
            BR_LT:             taken = ($signed(op_a_q) < $signed(op_b_q));
            BR_GE:             taken = ($signed(op_a_q) >= $signed(op_b_q));
            BR_JUMP, BR_JUMPR: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    assign is_jump    = (br_q == BR_JUMP) || (br_q == BR_JUMPR);
    assign target_o   = (br_q == BR_JUMPR) ? ((op_a_q + imm_q) & ~64'd1) : pc_q + imm_q;
    assign redirect_o = valid_q & taken;
    assign kill_o     = redirect_o;

    assign ex_valid_o  = valid_q;
    assign ex_pc_o     = pc_q;
    assign ex_rd_o     = rd_q;
    assign ex_we_o     = valid_q & we_q; // also qualifies forwarding
    assign ex_result_o = is_jump ? pc_q + 64'd4 : alu_res; // link value
    assign ex_ebreak_o = ebreak_q;

endmodule

// ==== fetch_unit.sv ====
// fetch unit: pc register, redirect and halt handling, fetch valid
`timescale 1ns/100ps
module fetch_unit (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     redirect_i,
    input  logic [seed_pkg::XLEN-1:0] target_i,
    input  logic                     halt_i,
    output logic [seed_pkg::XLEN-1:0] imem_addr_o,
    output logic [seed_pkg::XLEN-1:0] f_pc_o,
    output logic                     f_valid_o
);
    import seed_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            started_q; // low for the first cycle out of reset

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q      <= RESET_PC;
            started_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
            if (started_q && !halt_i) begin
                if (redirect_i)
                    pc_q <= target_i; // taken branch or jump
                else
                    pc_q <= pc_q + 64'd4;
            end
        end
    end

    assign imem_addr_o = pc_q;
    assign f_pc_o      = pc_q;
    assign f_valid_o   = started_q & ~halt_i;

endmodule

// ==== reg_file.sv ====
// register file with 31 64-bit registers, two bypassed read ports and x0 hardwired
`timescale 1ns/100ps
module reg_file (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [seed_pkg::REG_ADDR_W-1:0] ra1_i,
    input  logic [seed_pkg::REG_ADDR_W-1:0] ra2_i,
    output logic [seed_pkg::XLEN-1:0]       rd1_o,
    output logic [seed_pkg::XLEN-1:0]       rd2_o,
    input  logic                           we_i,
    input  logic [seed_pkg::REG_ADDR_W-1:0] wa_i,
    input  logic [seed_pkg::XLEN-1:0]       wd_i
);
    import seed_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] ra);
        if (ra == '0)
            return '0;
        if (we_i && wa_i == ra)
            return wd_i; // same-cycle write
        return regs[ra];
    endfunction

    always_comb begin
        rd1_o = read_port(ra1_i);
        rd2_o = read_port(ra2_i);
    end

endmodule

// ==== retire_unit.sv ====
// retire stage: stage register, retire port, register write and halt state
`timescale 1ns/100ps
module retire_unit (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           ex_valid_i,
    input  logic [seed_pkg::XLEN-1:0]       ex_pc_i,
    input  logic [seed_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  logic                           ex_we_i,
    input  logic [seed_pkg::XLEN-1:0]       ex_result_i,
    input  logic                           ex_ebreak_i,
    output logic                           wb_valid_o,
    output logic [seed_pkg::XLEN-1:0]       wb_pc_o,
    output logic                           wb_we_o,
    output logic [seed_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [seed_pkg::XLEN-1:0]       wb_data_o,
    output logic                           halt_o
);
    import seed_pkg::*;

    logic                  valid_q, we_q, ebreak_q, halted_q;
    logic [XLEN-1:0]       pc_q, data_q;
    logic [REG_ADDR_W-1:0] rd_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q  <= 1'b0;
            halted_q <= 1'b0;
        end else begin
            valid_q <= ex_valid_i & ~halt_o; // nothing retires past ebreak
            if (valid_q && ebreak_q)
                halted_q <= 1'b1;
        end
        pc_q     <= ex_pc_i;
        rd_q     <= ex_rd_i;
        we_q     <= ex_we_i;
        data_q   <= ex_result_i;
        ebreak_q <= ex_ebreak_i;
    end

    assign halt_o     = halted_q | (valid_q & ebreak_q); // rises with the ebreak retire
    assign wb_valid_o = valid_q;
    assign wb_pc_o    = pc_q;
    assign wb_we_o    = valid_q & we_q;
    assign wb_rd_o    = rd_q;
    assign wb_data_o  = data_q;

endmodule

// ==== rv_core.sv ====
// top level of the rv64i core: fetch, decode, register file, execute, retire
`timescale 1ns/100ps
module rv_core (
    input  logic                           clk,
    input  logic                           reset_i,
    output logic [seed_pkg::XLEN-1:0]       imem_addr_o,
    input  logic [seed_pkg::ILEN-1:0]       imem_data_i,
    output logic                           wb_valid_o,
    output logic [seed_pkg::XLEN-1:0]       wb_pc_o,
    output logic                           wb_we_o,
    output logic [seed_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [seed_pkg::XLEN-1:0]       wb_data_o,
    output logic                           halt_o
);
    import seed_pkg::*;

    logic                  f_valid, redirect, kill;
    logic [XLEN-1:0]       f_pc, target;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data;

    logic                  d_valid, d_we, d_use_imm, d_ebreak;
    logic [XLEN-1:0]       d_pc, d_op_a, d_op_b, d_imm;
    alu_op_e               d_alu_op;
    br_kind_e              d_br_kind;
    logic [REG_ADDR_W-1:0] d_rd;

    logic                  ex_valid, ex_we, ex_ebreak;
    logic [XLEN-1:0]       ex_pc, ex_result;
    logic [REG_ADDR_W-1:0] ex_rd;

    fetch_unit u_fetch (
        .clk(clk), .reset_i(reset_i),
        .redirect_i(redirect), .target_i(target), .halt_i(halt_o),
        .imem_addr_o(imem_addr_o), .f_pc_o(f_pc), .f_valid_o(f_valid)
    );

    decoder u_decoder (
        .clk(clk), .reset_i(reset_i),
        .f_pc_i(f_pc), .f_inst_i(imem_data_i), .f_valid_i(f_valid), .kill_i(kill),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_fwd_we_i(ex_we), .ex_fwd_rd_i(ex_rd), .ex_fwd_data_i(ex_result),
        .rt_fwd_we_i(wb_we_o), .rt_fwd_rd_i(wb_rd_o), .rt_fwd_data_i(wb_data_o),
        .d_valid_o(d_valid), .d_pc_o(d_pc), .d_op_a_o(d_op_a), .d_op_b_o(d_op_b),
        .d_imm_o(d_imm), .d_alu_op_o(d_alu_op), .d_br_kind_o(d_br_kind),
        .d_rd_o(d_rd), .d_we_o(d_we), .d_use_imm_o(d_use_imm), .d_ebreak_o(d_ebreak)
    );

    reg_file u_reg_file (
        .clk(clk), .reset_i(reset_i),
        .ra1_i(rs1_addr), .ra2_i(rs2_addr), .rd1_o(rs1_data), .rd2_o(rs2_data),
        .we_i(wb_we_o), .wa_i(wb_rd_o), .wd_i(wb_data_o) // written from retire
    );

    execute_unit u_execute (
        .clk(clk), .reset_i(reset_i),
        .d_valid_i(d_valid), .d_pc_i(d_pc), .d_op_a_i(d_op_a), .d_op_b_i(d_op_b),
        .d_imm_i(d_imm), .d_alu_op_i(d_alu_op), .d_br_kind_i(d_br_kind),
        .d_rd_i(d_rd), .d_we_i(d_we), .d_use_imm_i(d_use_imm), .d_ebreak_i(d_ebreak),
        .redirect_o(redirect), .target_o(target), .kill_o(kill),
        .ex_valid_o(ex_valid), .ex_pc_o(ex_pc), .ex_rd_o(ex_rd), .ex_we_o(ex_we),
        .ex_result_o(ex_result), .ex_ebreak_o(ex_ebreak)
    );

    retire_unit u_retire (
        .clk(clk), .reset_i(reset_i),
        .ex_valid_i(ex_valid), .ex_pc_i(ex_pc), .ex_rd_i(ex_rd), .ex_we_i(ex_we),
        .ex_result_i(ex_result), .ex_ebreak_i(ex_ebreak),
        .wb_valid_o(wb_valid_o), .wb_pc_o(wb_pc_o), .wb_we_o(wb_we_o),
        .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .halt_o(halt_o)
    );

endmodule

// ==== seed_pkg.sv ====
// widths, reset pc, opcode / alu / branch enums and funct3 codes for the core
package seed_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC    = 64'h0;
    localparam logic [ILEN-1:0] EBREAK_INST = 32'h0010_0073;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JUMP,  // jal
        BR_JUMPR  // jalr
    } br_kind_e;

    // funct3 of OP / OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 of BRANCH and JALR
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_JALR = 3'b000;

endpackage

// ==== tb.f ====
+incdir+.
seed_pkg.sv
fetch_unit.sv
decoder.sv
reg_file.sv
execute_unit.sv
retire_unit.sv
rv_core.sv
tb_core.sv

// ==== tb_program.svh ====
// xorshift generator, instruction encoders, program builder and reference retire model
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

task automatic emit(input logic [31:0] inst);
    imem[prog_len] = inst;
    prog_len++;
endtask

task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    int          k;
    logic [2:0]  br_f3 [4];
    br_f3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE};
    // unused words hold addi x0, x0, index
    for (int i = 0; i < PROG_WORDS; i++)
        imem[i] = enc_i(12'(i), 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM);
    prog_len = 0;
    // random alu ops on x0..x7 so that most depend on the one before
    for (int i = 0; i < 32; i++) begin
        r   = next_random();
        rd  = {2'b0, r[2:0]};
        rs1 = {2'b0, r[5:3]};
        rs2 = {2'b0, r[8:6]};
        f3  = r[11:9];
        case (r[13:12])
            2'd0, 2'd1: begin
                f7 = (r[14] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ? 7'h20 : 7'h00;
                emit(enc_r(f7, rs2, rs1, f3, rd, OPC_OP));
            end
            2'd2: begin
                if (f3 == F3_SLL)
                    imm = {6'b0, r[20:15]};
                else if (f3 == F3_SRL_SRA)
                    imm = {1'b0, r[14], 4'b0, r[20:15]};
                else
                    imm = r[26:15];
                emit(enc_i(imm, rs1, f3, rd, OPC_OP_IMM));
            end
            default: emit({r[31:12], rd, OPC_LUI});
        endcase
    end
    emit(enc_i(12'd5, 5'd1, F3_ADD_SUB, 5'd0, OPC_OP_IMM)); // write to x0
    emit(enc_r(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd6, OPC_OP));
    emit(enc_r(7'h00, 5'd3, 5'd0, F3_OR, 5'd7, OPC_OP));
    emit(enc_i(12'hffd, 5'd0, F3_ADD_SUB, 5'd10, OPC_OP_IMM)); // x10 = -3
    emit(enc_i(12'd5, 5'd0, F3_ADD_SUB, 5'd11, OPC_OP_IMM));
    for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 3; j++) begin
            rs1 = (j == 1) ? 5'd11 : 5'd10;
            rs2 = (j == 0) ? 5'd11 : 5'd10;
            emit(enc_b(13'd12, rs2, rs1, br_f3[i]));
            emit(enc_i(12'd1, 5'd12, F3_ADD_SUB, 5'd12, OPC_OP_IMM)); // shadow when taken
            emit(enc_i(12'd2, 5'd12, F3_ADD_SUB, 5'd12, OPC_OP_IMM));
        end
    end
    emit(enc_j(21'd12, 5'd1));
    emit(enc_i(12'd3, 5'd12, F3_ADD_SUB, 5'd12, OPC_OP_IMM));
    emit(enc_i(12'd4, 5'd12, F3_ADD_SUB, 5'd12, OPC_OP_IMM));
    k = prog_len;
    emit(enc_i(12'((k + 4) * 4), 5'd0, F3_ADD_SUB, 5'd13, OPC_OP_IMM));
    emit(enc_i(12'd0, 5'd13, F3_JALR, 5'd5, OPC_JALR));
    emit(enc_i(12'd5, 5'd12, F3_ADD_SUB, 5'd12, OPC_OP_IMM));
    emit(enc_i(12'd6, 5'd12, F3_ADD_SUB, 5'd12, OPC_OP_IMM));
    emit(enc_r(7'h00, 5'd1, 5'd5, F3_ADD_SUB, 5'd14, OPC_OP)); // both link values
    emit(EBREAK_INST);
endtask

// in-order model of the program with one expected retire record per instruction
task automatic run_model();
    logic [63:0] rf [32];
    logic [63:0] pc, a, b, nxt, imm_i, imm_b, imm_j;
    logic [31:0] inst;
    rec_t        rec;
    bit          done;
    for (int i = 0; i < 32; i++)
        rf[i] = '0;
    pc   = RESET_PC;
    done = 1'b0;
    for (int step = 0; step < PROG_WORDS && !done; step++) begin
        inst  = imem[pc[9:2]];
        a     = rf[inst[19:15]];
        b     = rf[inst[24:20]];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        nxt   = pc + 64'd4;
        rec.pc   = pc;
        rec.we   = 1'b0;
        rec.rd   = inst[11:7];
        rec.data = '0;
        rec.name = "branch";
        case (inst[6:0])
            OPC_OP, OPC_OP_IMM: begin
                if (inst[6:0] == OPC_OP_IMM)
                    b = imm_i;
                rec.we   = 1'b1;
                rec.name = "alu";
                case (inst[14:12])
                    F3_ADD_SUB: rec.data = (inst[6:0] == OPC_OP && inst[30]) ? a - b : a + b;
                    F3_SLL:     rec.data = a << b[5:0];
                    F3_SLT:     rec.data = {63'b0, $signed(a) < $signed(b)};
                    F3_SLTU:    rec.data = {63'b0, a < b};
                    F3_XOR:     rec.data = a ^ b;
                    F3_SRL_SRA: rec.data = inst[30] ? $unsigned($signed(a) >>> b[5:0])
                                                    : a >> b[5:0];
                    F3_OR:      rec.data = a | b;
                    default:    rec.data = a & b;
                endcase
            end
            OPC_LUI: begin
                rec.we   = 1'b1;
                rec.data = {{32{inst[31]}}, inst[31:12], 12'b0};
                rec.name = "lui";
            end
            OPC_BRANCH: begin
                case (inst[14:12])
                    F3_BEQ:  if (a == b) nxt = pc + imm_b;
                    F3_BNE:  if (a != b) nxt = pc + imm_b;
                    F3_BLT:  if ($signed(a) < $signed(b)) nxt = pc + imm_b;
                    default: if ($signed(a) >= $signed(b)) nxt = pc + imm_b;
                endcase
            end
            OPC_JAL: begin
                rec.we   = 1'b1;
                rec.data = pc + 64'd4;
                rec.name = "jal";
                nxt      = pc + imm_j;
            end
            OPC_JALR: begin
                rec.we   = 1'b1;
                rec.data = pc + 64'd4;
                rec.name = "jalr";
                nxt      = (a + imm_i) & ~64'd1;
            end
            default: begin
                rec.name = "ebreak";
                done     = 1'b1;
            end
        endcase
        if (rec.we && rec.rd == 5'd0)
            rec.name = "x0_write";
        if (rec.we && rec.rd != 5'd0)
            rf[rec.rd] = rec.data;
        exp_q.push_back(rec);
        pc = nxt;
    end
endtask

`endif

// ==== tb_core.sv ====
// clock, reset, instruction memory and retire checks of the rv_core testbench
`timescale 1ns/100ps
module tb_core;
    import seed_pkg::*;

    localparam int          PROG_WORDS   = 256;
    localparam logic [31:0] SEED         = 32'd95;
    localparam int          MAX_CYCLES   = 600;  // bound on the wait for halt
    localparam int          QUIET_CYCLES = 20;
    localparam int          FIRST_RETIRE = 4;    // one dead fetch cycle, then 3 stages

    typedef struct {
        logic [63:0] pc;
        logic        we;
        logic [4:0]  rd;
        logic [63:0] data;
        string       name;
    } rec_t;

    logic        clk;
    logic        reset_i;
    logic [63:0] imem_addr;
    logic [31:0] imem_data;
    logic        wb_valid, wb_we, halt;
    logic [63:0] wb_pc, wb_data;
    logic [4:0]  wb_rd;

    logic [31:0] imem [PROG_WORDS];
    logic [31:0] rng_state;
    int          prog_len;
    rec_t        exp_q [$];
    bit          seen_first;
    bit          halt_seen;
    logic [63:0] halt_addr; // fetch pc frozen three words past the ebreak

    `include "tb_program.svh"

    rv_core UUT (
        .clk(clk), .reset_i(reset_i),
        .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .wb_valid_o(wb_valid), .wb_pc_o(wb_pc), .wb_we_o(wb_we),
        .wb_rd_o(wb_rd), .wb_data_o(wb_data), .halt_o(halt)
    );

    assign imem_data = imem[imem_addr[9:2]]; // answered in the same cycle

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
        stop_with_failure("a checked value does not match its expected value");
    endtask

    task automatic check_retire();
        rec_t e;
        if (exp_q.size() == 0) begin
            stop_with_failure("an instruction retired after the program had ended");
        end else begin
            e = exp_q.pop_front();
            assert (wb_pc == e.pc) else report_mismatch({e.name, " pc"}, e.pc, wb_pc);
            assert (wb_we == e.we)
                else report_mismatch({e.name, " we"}, 64'(e.we), 64'(wb_we));
            assert (halt == (e.name == "ebreak"))
                else report_mismatch({e.name, " halt"}, 64'(e.name == "ebreak"), 64'(halt));
            if (e.we) begin
                assert (wb_rd == e.rd)
                    else report_mismatch({e.name, " rd"}, 64'(e.rd), 64'(wb_rd));
                assert (wb_data == e.data)
                    else report_mismatch({e.name, " data"}, e.data, wb_data);
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset_i    = 1'b1;
        rng_state  = SEED;
        seen_first = 1'b0;
        halt_seen  = 1'b0;
        build_program();
        run_model();
        halt_addr = exp_q[$].pc + 64'd12;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        for (int cyc = 0; cyc < MAX_CYCLES && !halt_seen; cyc++) begin
            @(negedge clk);
            if (!seen_first) begin
                assert (!halt) else report_mismatch("reset halt", 64'd0, 64'(halt));
            end
            if (wb_valid) begin
                if (!seen_first) begin
                    assert (cyc == FIRST_RETIRE)
                        else report_mismatch("first retire cycle", 64'(FIRST_RETIRE), 64'(cyc));
                    seen_first = 1'b1;
                end
                check_retire();
            end
            halt_seen = halt;
        end
        if (!halt_seen)
            stop_with_failure("timeout: halt_o never rose");
        // halted core stays quiet
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (!wb_valid) else report_mismatch("after halt valid", 64'd0, 64'(wb_valid));
            assert (halt) else report_mismatch("halt held", 64'd1, 64'(halt));
            assert (imem_addr == halt_addr)
                else report_mismatch("halted fetch pc", halt_addr, imem_addr);
        end
        assert (exp_q.size() == 0)
            else report_mismatch("model queue empty", 64'd0, 64'(exp_q.size()));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
